// ==== flist.f ====
verilog/cpuPkg.sv
verilog/regFile.sv
verilog/alu.sv
verilog/decodeCtrl.sv
verilog/hazardUnit.sv
verilog/localMem.sv
verilog/cpu.sv
verification/clkGen.sv
verification/cpuHazard_props.sv
verification/cpuTb.sv

// ==== Makefile ====
sim:
	verilator --binary --timing --assert -Wno-fatal --top-module cpuTb \
		-f flist.f --Mdir obj_dir -o cpuTb
	./obj_dir/cpuTb > sim.log 2>&1; cat sim.log
	grep -q "^TEST PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== verification/cpuTb.sv ====
`timescale 1ns/1ps

module cpuTb
    import cpuPkg::*;
;

    logic   clk, rst, loadEn, hlt, wbValid, stValid;
    wordT   loadAddr, loadData, pc, wbData, stAddr, stData;
    regIdxT wbReg;

    wordT   prog[$];
    regIdxT expWbReg[$];
    wordT   expWbData[$], expStAddr[$], expStData[$];
    wordT   hltAddr;
    integer seed = 32'h8f03;

    clkGen clock (.clk(clk));

    cpu DUT (
        .clk(clk), .rst(rst), .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
        .hlt(hlt), .pc(pc), .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
        .stValid(stValid), .stAddr(stAddr), .stData(stData)
    );

    task automatic stopOnError(string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    function automatic wordT encode(opcodeE op, logic [3:0] a, logic [3:0] b, logic [3:0] c);
        return {op, a, b, c};
    endfunction

    function automatic wordT encodeBranch(condE c, logic [8:0] off);
        return {OP_B, c, off};
    endfunction

    // ISA model that fills the expected event queues
    function automatic void refRun();
        wordT       r[16];
        wordT       dm[MEM_DEPTH];
        logic       z, v, n, taken, wr;
        int         pcIdx, steps, sum;
        wordT       ins, a, b, res, addr;
        opcodeE     op;
        logic [3:0] rd;
        for (int i = 0; i < 16; i++) r[i] = '0;
        for (int i = 0; i < MEM_DEPTH; i++) dm[i] = '0;
        {z, v, n} = 3'b000;
        pcIdx = 0;
        for (steps = 0; steps < 1000 && pcIdx < prog.size(); steps++) begin
            ins  = prog[pcIdx];
            op   = opcodeE'(ins[15:12]);
            rd   = ins[11:8];
            a    = r[ins[7:4]];
            b    = r[ins[3:0]];
            addr = a + {{11{ins[3]}}, ins[3:0], 1'b0};
            wr   = 1'b1;
            pcIdx++;
            case (op)
                OP_ADD, OP_SUB: begin
                    res = (op == OP_ADD) ? a + b : a - b;
                    sum = (op == OP_ADD) ? $signed(a) + $signed(b) : $signed(a) - $signed(b);
                    z = (res == 0);
                    n = res[15];
                    v = (sum > 32767) || (sum < -32768);
                end
                OP_XOR: begin
                    res = a ^ b;
                    z = (res == 0);
                end
                OP_SLL: begin
                    res = a << ins[3:0];
                    z = (res == 0);
                end
                OP_LW:  res = dm[addr[8:1]];
                OP_LDI: res = {8'h00, ins[7:0]};
                OP_SW: begin
                    wr = 1'b0;
                    dm[addr[8:1]] = r[rd];
                    expStAddr.push_back(addr);
                    expStData.push_back(r[rd]);
                end
                OP_B: begin
                    wr = 1'b0;
                    case (condE'(ins[11:9]))
                        COND_NE: taken = !z;
                        COND_EQ: taken = z;
                        COND_GT: taken = !z && !n;
                        COND_LT: taken = n;
                        COND_GE: taken = z || !n;
                        COND_LE: taken = z || n;
                        COND_OV: taken = v;
                        default: taken = 1'b1;
                    endcase
                    if (taken) pcIdx += $signed(ins[8:0]);
                end
                OP_HLT: begin
                    hltAddr = wordT'((pcIdx - 1) * 2);
                    return;
                end
                default: wr = 1'b0;
            endcase
            if (wr && rd != 0) begin
                r[rd] = res;
                expWbReg.push_back(rd);
                expWbData.push_back(res);
            end
        end
    endfunction

    task automatic checkWb(regIdxT expReg, wordT expData);
        if (wbReg !== expReg) begin
            $display("FAIL wbReg expected %h got %h", expReg, wbReg);
            stopOnError("write-back register mismatch");
        end else if (wbData !== expData) begin
            $display("FAIL wbData expected %h got %h", expData, wbData);
            stopOnError("write-back data mismatch");
        end
    endtask

    task automatic checkSt(wordT expAddr, wordT expData);
        if (stAddr !== expAddr) begin
            $display("FAIL stAddr expected %h got %h", expAddr, stAddr);
            stopOnError("store address mismatch");
        end else if (stData !== expData) begin
            $display("FAIL stData expected %h got %h", expData, stData);
            stopOnError("store data mismatch");
        end
    endtask

    // Outputs are stable by the falling edge
    always @(negedge clk) begin
        if (!rst && wbValid) begin
            if (expWbReg.size() == 0) stopOnError("unexpected write-back event");
            else checkWb(expWbReg.pop_front(), expWbData.pop_front());
        end
        if (!rst && stValid) begin
            if (expStAddr.size() == 0) stopOnError("unexpected store event");
            else checkSt(expStAddr.pop_front(), expStData.pop_front());
        end
    end

    task automatic loadAndRun(string name);
        int cyc;
        rst = 1'b1;
        refRun();
        for (int i = 0; i < prog.size(); i++) begin
            loadEn   = 1'b1;
            loadAddr = wordT'(i * 2);
            loadData = prog[i];
            @(posedge clk);
            #1;
        end
        loadEn = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        cyc = 0;
        while (!hlt && cyc < 2000) begin
            @(posedge clk);
            #1;
            cyc++;
        end
        if (!hlt) begin
            stopOnError({"timeout waiting for hlt in program ", name});
        end else begin
            // Late events within this window trip the comparison process
            repeat (8) @(posedge clk);
            #1;
            if (expWbReg.size() != 0 || expStAddr.size() != 0) begin
                stopOnError({"expected events missing in program ", name});
            end else if (pc !== hltAddr) begin
                $display("FAIL pc expected %h got %h", hltAddr, pc);
                stopOnError({"pc not at the HLT address in program ", name});
            end
        end
    endtask

    task automatic randomProgram(int len);
        int k, rem;
        prog.delete();
        for (int i = 1; i <= 3; i++) begin
            k = $random(seed);
            prog.push_back(encode(OP_LDI, 4'(i), k[7:4], k[3:0]));
        end
        for (int i = 3; i < len; i++) begin
            k   = $random(seed);
            rem = len - i - 1;
            case ({$random(seed)} % 7)
                0: prog.push_back(encode(OP_LDI, 4'(1 + k[2:0] % 7), k[11:8], k[15:12]));
                1: prog.push_back(encode(OP_LW, 4'(1 + k[2:0] % 7), {1'b0, k[6:4]}, k[11:8]));
                2: prog.push_back(encode(OP_SW, {1'b0, k[2:0]}, {1'b0, k[6:4]}, k[11:8]));
                3: prog.push_back(encodeBranch(condE'(k[2:0]), 9'({k[15:4]} % (rem + 1))));
                default: prog.push_back(encode(opcodeE'(k[13:12]), 4'(1 + k[2:0] % 7),
                                               {1'b0, k[6:4]}, k[11:8]));
            endcase
        end
        prog.push_back(encode(OP_HLT, 0, 0, 0));
    endtask

    initial begin
        logic [7:0] idx;
        rst      = 1'b1;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        @(posedge clk);
        #1;
        // ALU chains with forwarding and a discarded write to R0
        prog = '{encode(OP_LDI, 1, 0, 5), encode(OP_LDI, 2, 0, 3), encode(OP_ADD, 3, 1, 2),
                 encode(OP_SUB, 4, 3, 1), encode(OP_XOR, 5, 4, 3), encode(OP_SLL, 6, 5, 2),
                 encode(OP_ADD, 7, 6, 6), encode(OP_SUB, 8, 2, 7), encode(OP_LDI, 0, 0, 9),
                 encode(OP_ADD, 9, 0, 1), encode(OP_HLT, 0, 0, 0)};
        loadAndRun("alu");
        // Load-use, store after load, negative offset
        prog = '{encode(OP_LDI, 1, 4, 0), encode(OP_LDI, 2, 7, 7), encode(OP_SW, 2, 1, 0),
                 encode(OP_LW, 3, 1, 0), encode(OP_ADD, 4, 3, 3), encode(OP_LW, 5, 1, 0),
                 encode(OP_SW, 5, 1, 2), encode(OP_SW, 4, 1, 4'hf), encode(OP_LW, 6, 1, 2),
                 encode(OP_XOR, 7, 6, 4), encode(OP_HLT, 0, 0, 0)};
        loadAndRun("memory");
        // Every condition right after zero, negative, positive and overflow results
        prog = '{encode(OP_LDI, 1, 0, 5), encode(OP_LDI, 2, 0, 3), encode(OP_LDI, 3, 7, 15),
                 encode(OP_SLL, 4, 3, 8)};
        for (int c = 0; c < 8; c++) begin
            for (int f = 0; f < 4; f++) begin
                idx = 8'(c * 4 + f + 1);
                case (f)
                    0: prog.push_back(encode(OP_SUB, 7, 1, 1));
                    1: prog.push_back(encode(OP_SUB, 7, 2, 1));
                    2: prog.push_back(encode(OP_SUB, 7, 1, 2));
                    default: prog.push_back(encode(OP_ADD, 7, 4, 4));
                endcase
                prog.push_back(encodeBranch(condE'(c), 9'd1));
                prog.push_back(encode(OP_LDI, 10, idx[7:4], idx[3:0]));
            end
        end
        prog.push_back(encode(OP_HLT, 0, 0, 0));
        loadAndRun("branch");
        // Nothing after HLT may retire
        prog = '{encode(OP_LDI, 1, 0, 1), encode(OP_HLT, 0, 0, 0), encode(OP_LDI, 2, 0, 2),
                 encode(OP_SW, 1, 0, 0), encode(OP_LDI, 3, 0, 3)};
        loadAndRun("halt");
        for (int p = 0; p < 20; p++) begin
            randomProgram(28);
            loadAndRun($sformatf("random %0d", p));
        end
        if (DUT.props.failCount != 0) begin
            stopOnError("bound assertions reported failures");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

// ==== verification/cpuHazard_props.sv ====
`timescale 1ns/1ps

module cpuProps (
    input logic        clk,
    input logic        rst,
    input logic        loadStall,
    input logic        branchTaken,
    input logic        wbValid,
    input logic [3:0]  wbReg,
    input logic [15:0] wbData,
    input logic        hlt,
    input logic [15:0] pc
);

    int failCount = 0;

    // Branches name no source registers so a load stall never meets a taken branch
    stallFlushExclusive: assert property (@(posedge clk) disable iff (rst)
        !(loadStall && branchTaken))
        else begin
            failCount++;
            $error("load stall and taken branch in the same cycle");
        end

    noWbToR0: assert property (@(posedge clk) disable iff (rst)
        wbValid |-> wbReg != 4'd0 && !$isunknown(wbData))
        else begin
            failCount++;
            $error("write-back names R0 or carries unknown data");
        end

    // Fetch stays frozen on the HLT word once it retires
    hltSticky: assert property (@(posedge clk) disable iff (rst)
        $past(hlt) |-> hlt && $stable(pc))
        else begin
            failCount++;
            $error("hlt fell or pc moved after halt");
        end

endmodule

bind cpu cpuProps props (
    .clk(clk), .rst(rst), .loadStall(loadStall), .branchTaken(branchTaken),
    .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData), .hlt(hlt), .pc(pc)
);

// ==== verification/clkGen.sv ====
`timescale 1ns/1ps

module clkGen (
    output logic clk
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

endmodule

// ==== verilog/cpu.sv ====
`timescale 1ns/1ps

module cpu
    import cpuPkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   loadEn,
    input  wordT   loadAddr,
    input  wordT   loadData,
    output logic   hlt,
    output wordT   pc,
    output logic   wbValid,
    output regIdxT wbReg,
    output wordT   wbData,
    output logic   stValid,
    output wordT   stAddr,
    output wordT   stData
);

    // Fetch
    wordT       fInstr, fIncPc;
    logic       fHlt;
    // Decode
    wordT       dInstr, dIncPc, dRegData1, dRegData2, branchTarget;
    logic       dRegWrite, dMemRead, dMemWrite, dIsHlt, dZEn, dVEn, dNEn;
    aluOpE      dAluOp;
    logic [1:0] dImmSel;
    regIdxT     dSrcRs, dSrcRt, hzIdRt;
    logic       branchTaken, takeBranch, idIsBranch, loadStall, branchStall, stall;
    // Execute
    logic       xRegWrite, xMemRead, xMemWrite, xIsHlt, xZEn, xVEn, xNEn;
    aluOpE      xAluOp;
    logic [1:0] xImmSel;
    regIdxT     xRs, xRt, xRd;
    logic [7:0] xImm8;
    wordT       xRegData1, xRegData2, opA, rtVal, opB, xAluOut;
    fwdSelE     fwdA, fwdB;
    logic [2:0] flagsIn, flags;
    // Memory
    logic       mRegWrite, mMemRead, mMemWrite, mIsHlt, memFwd;
    regIdxT     mRd, mRt;
    wordT       mAluOut, mStoreData, mMemData, storeData;
    // Write-back
    logic       wRegWrite, wMemToReg, wIsHlt, hltSeen;
    regIdxT     wRd;
    wordT       wAluOut, wMemData, wData;

    function automatic wordT fwdMux(fwdSelE sel, wordT regVal);
        case (sel)
            FWD_MEM: return mAluOut;
            FWD_WB:  return wData;
            default: return regVal;
        endcase
    endfunction

    assign fIncPc     = pc + 16'd2;
    assign fHlt       = opcodeE'(fInstr[15:12]) == OP_HLT;
    assign stall      = loadStall | branchStall;
    assign takeBranch = branchTaken & ~stall;

    // HLT in fetch holds the PC unless decode redirects it
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (takeBranch) begin
            pc <= branchTarget;
        end else if (!stall && !fHlt) begin
            pc <= fIncPc;
        end
    end

    // Program preload only while reset is held
    localMem instrMem (
        .clk(clk), .rst(rst), .rdAddr(pc), .rdData(fInstr), .wrEn(loadEn & rst),
        .wrAddr(loadAddr), .wrData(loadData), .clrOnReset(1'b0)
    );

    // IF/ID, flushed by a taken branch
    always_ff @(posedge clk) begin
        if (rst || takeBranch) begin
            dInstr <= NOP_INSTR;
        end else if (!stall) begin
            dInstr <= fInstr;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            dIncPc <= fIncPc;
        end
    end

    regFile regs (
        .clk(clk), .rst(rst), .rdAddr1(dSrcRs), .rdAddr2(dSrcRt), .wrEn(wRegWrite),
        .wrAddr(wRd), .wrData(wData), .rdData1(dRegData1), .rdData2(dRegData2)
    );

    decodeCtrl ctrl (
        .instr(dInstr), .incPc(dIncPc), .flags(flags), .regWrite(dRegWrite),
        .memRead(dMemRead), .memWrite(dMemWrite), .isHlt(dIsHlt), .aluOp(dAluOp),
        .immSel(dImmSel), .zEn(dZEn), .vEn(dVEn), .nEn(dNEn), .srcRs(dSrcRs),
        .srcRt(dSrcRt), .branchTaken(branchTaken), .branchTarget(branchTarget)
    );

    assign idIsBranch = opcodeE'(dInstr[15:12]) == OP_B;
    // Store data is covered by forwarding, so it never causes a load-use stall
    assign hzIdRt     = dMemWrite ? '0 : dSrcRt;

    hazardUnit hazard (
        .idRs(dSrcRs), .idRt(hzIdRt), .exRd(xRd), .memRd(mRd), .wbRd(wRd),
        .idIsBranch(idIsBranch), .exMemRead(xMemRead), .exRegWrite(xRegWrite),
        .memRegWrite(mRegWrite & ~mMemRead), .wbRegWrite(wRegWrite),
        .exFlagWrite(xZEn | xVEn | xNEn), .memMemWrite(mMemWrite), .exRs(xRs),
        .exRt(xRt), .memRt(mRt), .exUsesRt(xImmSel == IMM_RT || xMemWrite),
        .loadStall(loadStall), .branchStall(branchStall), .fwdA(fwdA), .fwdB(fwdB),
        .memFwd(memFwd)
    );

    // ID/EX, bubble on either stall
    always_ff @(posedge clk) begin
        if (rst || stall) begin
            {xRegWrite, xMemRead, xMemWrite, xIsHlt} <= 4'b0000;
            {xZEn, xVEn, xNEn} <= 3'b000;
        end else begin
            {xRegWrite, xMemRead, xMemWrite, xIsHlt} <= {dRegWrite, dMemRead, dMemWrite, dIsHlt};
            {xZEn, xVEn, xNEn} <= {dZEn, dVEn, dNEn};
        end
    end

    always_ff @(posedge clk) begin
        xAluOp    <= dAluOp;
        xImmSel   <= dImmSel;
        xRs       <= dSrcRs;
        xRt       <= dSrcRt;
        xRd       <= dInstr[11:8];
        xImm8     <= dInstr[7:0];
        xRegData1 <= dRegData1;
        xRegData2 <= dRegData2;
    end

    assign opA   = fwdMux(fwdA, xRegData1);
    assign rtVal = fwdMux(fwdB, xRegData2);

    always_comb begin
        case (xImmSel)
            IMM_SHAMT:  opB = {12'h000, xImm8[3:0]};
            IMM_OFFSET: opB = {{11{xImm8[3]}}, xImm8[3:0], 1'b0};
            IMM_BYTE:   opB = {8'h00, xImm8};
            default:    opB = rtVal;
        endcase
    end

    alu exAlu (.opA(opA), .opB(opB), .aluOp(xAluOp), .result(xAluOut), .flagsIn(flagsIn));

    // Flag order Z V N
    always_ff @(posedge clk) begin
        if (rst) begin
            flags <= 3'b000;
        end else begin
            if (xZEn) flags[2] <= flagsIn[2];
            if (xVEn) flags[1] <= flagsIn[1];
            if (xNEn) flags[0] <= flagsIn[0];
        end
    end

    // EX/MEM
    always_ff @(posedge clk) begin
        if (rst) begin
            {mRegWrite, mMemRead, mMemWrite, mIsHlt} <= 4'b0000;
        end else begin
            {mRegWrite, mMemRead, mMemWrite, mIsHlt} <= {xRegWrite, xMemRead, xMemWrite, xIsHlt};
        end
        mRd        <= xRd;
        mRt        <= xRt;
        mAluOut    <= xAluOut;
        mStoreData <= rtVal;
    end

    assign storeData = memFwd ? wData : mStoreData;

    localMem dataMem (
        .clk(clk), .rst(rst), .rdAddr(mAluOut), .rdData(mMemData), .wrEn(mMemWrite),
        .wrAddr(mAluOut), .wrData(storeData), .clrOnReset(1'b1)
    );

    assign stValid = mMemWrite;
    assign stAddr  = mAluOut;
    assign stData  = storeData;

    // MEM/WB
    always_ff @(posedge clk) begin
        if (rst) begin
            {wRegWrite, wMemToReg, wIsHlt} <= 3'b000;
        end else begin
            {wRegWrite, wMemToReg, wIsHlt} <= {mRegWrite, mMemRead, mIsHlt};
        end
        wRd      <= mRd;
        wAluOut  <= mAluOut;
        wMemData <= mMemData;
    end

    assign wData   = wMemToReg ? wMemData : wAluOut;
    assign wbValid = wRegWrite && wRd != '0;
    assign wbReg   = wRd;
    assign wbData  = wData;

    // Sticky once HLT retires
    always_ff @(posedge clk) begin
        if (rst) begin
            hltSeen <= 1'b0;
        end else if (wIsHlt) begin
            hltSeen <= 1'b1;
        end
    end

    assign hlt = hltSeen | wIsHlt;

endmodule

// ==== verilog/localMem.sv ====
`timescale 1ns/1ps

module localMem
    import cpuPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  wordT rdAddr,
    output wordT rdData,
    input  logic wrEn,
    input  wordT wrAddr,
    input  wordT wrData,
    input  logic clrOnReset
);

    wordT mem [MEM_DEPTH];

    // Byte address to word index
    assign rdData = mem[rdAddr[MEM_AW:1]];

    always_ff @(posedge clk) begin
        if (rst && clrOnReset) begin
            for (int i = 0; i < MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wrEn) begin
            mem[wrAddr[MEM_AW:1]] <= wrData;
        end
    end

endmodule

// ==== verilog/hazardUnit.sv ====
`timescale 1ns/1ps

module hazardUnit
    import cpuPkg::*;
(
    input  regIdxT idRs,
    input  regIdxT idRt,
    input  regIdxT exRd,
    input  regIdxT memRd,
    input  regIdxT wbRd,
    input  logic   idIsBranch,
    input  logic   exMemRead,
    input  logic   exRegWrite,
    input  logic   memRegWrite,
    input  logic   wbRegWrite,
    input  logic   exFlagWrite,
    input  logic   memMemWrite,
    input  regIdxT exRs,
    input  regIdxT exRt,
    input  regIdxT memRt,
    input  logic   exUsesRt,
    output logic   loadStall,
    output logic   branchStall,
    output fwdSelE fwdA,
    output fwdSelE fwdB,
    output logic   memFwd
);

    // Newest producer wins, R0 is never forwarded
    function automatic fwdSelE pickSrc(regIdxT src);
        if (src == '0) begin
            return FWD_NONE;
        end
        if (memRegWrite && memRd == src) begin
            return FWD_MEM;
        end
        if (wbRegWrite && wbRd == src) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    always_comb begin
        loadStall   = exMemRead && exRegWrite && exRd != '0 &&
                      (exRd == idRs || exRd == idRt);
        // Flags are only valid once the producer has left EX
        branchStall = idIsBranch && exFlagWrite;
        fwdA        = pickSrc(exRs);
        fwdB        = exUsesRt ? pickSrc(exRt) : FWD_NONE;
        // Load result reaching a store right behind it
        memFwd      = memMemWrite && wbRegWrite && wbRd != '0 && wbRd == memRt;
    end

endmodule

// ==== verilog/decodeCtrl.sv ====
`timescale 1ns/1ps

module decodeCtrl
    import cpuPkg::*;
(
    input  wordT       instr,
    input  wordT       incPc,
    input  logic [2:0] flags,
    output logic       regWrite,
    output logic       memRead,
    output logic       memWrite,
    output logic       isHlt,
    output aluOpE      aluOp,
    output logic [1:0] immSel,
    output logic       zEn,
    output logic       vEn,
    output logic       nEn,
    output regIdxT     srcRs,
    output regIdxT     srcRt,
    output logic       branchTaken,
    output wordT       branchTarget
);

    opcodeE op;
    condE   cond;
    logic   z, v, n;
    logic   condMet;

    assign op        = opcodeE'(instr[15:12]);
    assign cond      = condE'(instr[11:9]);
    assign {z, v, n} = flags;

    always_comb begin
        regWrite = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        isHlt    = 1'b0;
        aluOp    = ALU_ADD;
        immSel   = IMM_RT;
        {zEn, vEn, nEn} = 3'b000;
        // Unused sources stay at R0 so they never stall or forward
        srcRs    = '0;
        srcRt    = '0;
        case (op)
            OP_ADD, OP_SUB: begin
                regWrite = 1'b1;
                aluOp    = (op == OP_SUB) ? ALU_SUB : ALU_ADD;
                srcRs    = instr[7:4];
                srcRt    = instr[3:0];
                {zEn, vEn, nEn} = 3'b111;
            end
            OP_XOR: begin
                regWrite = 1'b1;
                aluOp    = ALU_XOR;
                srcRs    = instr[7:4];
                srcRt    = instr[3:0];
                zEn      = 1'b1;
            end
            OP_SLL: begin
                regWrite = 1'b1;
                aluOp    = ALU_SLL;
                immSel   = IMM_SHAMT;
                srcRs    = instr[7:4];
                zEn      = 1'b1;
            end
            OP_LW: begin
                regWrite = 1'b1;
                memRead  = 1'b1;
                immSel   = IMM_OFFSET;
                srcRs    = instr[7:4];
            end
            OP_SW: begin
                memWrite = 1'b1;
                immSel   = IMM_OFFSET;
                srcRs    = instr[7:4];
                srcRt    = instr[11:8];
            end
            OP_LDI: begin
                // R0 as first operand, so the byte passes through the adder
                regWrite = 1'b1;
                immSel   = IMM_BYTE;
            end
            OP_HLT: isHlt = 1'b1;
            default: ;
        endcase
    end

    always_comb begin
        case (cond)
            COND_NE: condMet = ~z;
            COND_EQ: condMet = z;
            COND_GT: condMet = ~z & ~n;
            COND_LT: condMet = n;
            COND_GE: condMet = z | ~n;
            COND_LE: condMet = n | z;
            COND_OV: condMet = v;
            default: condMet = 1'b1;
        endcase
    end

    assign branchTaken  = (op == OP_B) && condMet;
    assign branchTarget = incPc + {{6{instr[8]}}, instr[8:0], 1'b0};

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/1ps

module alu
    import cpuPkg::*;
(
    input  wordT       opA,
    input  wordT       opB,
    input  aluOpE      aluOp,
    output wordT       result,
    output logic [2:0] flagsIn
);

    wordT sum;
    wordT diff;
    logic ovf;

    assign sum  = opA + opB;
    assign diff = opA - opB;

    always_comb begin
        ovf = 1'b0;
        case (aluOp)
            ALU_ADD: begin
                result = sum;
                // Same-sign operands, result sign differs
                ovf    = (opA[15] == opB[15]) && (sum[15] != opA[15]);
            end
            ALU_SUB: begin
                result = diff;
                ovf    = (opA[15] != opB[15]) && (diff[15] != opA[15]);
            end
            ALU_XOR: begin
                result = opA ^ opB;
            end
            default: begin
                result = opA << opB[3:0];
            end
        endcase
    end

    // Z V N
    assign flagsIn = {result == '0, ovf, result[15]};

endmodule

// ==== verilog/regFile.sv ====
`timescale 1ns/1ps

module regFile
    import cpuPkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  regIdxT rdAddr1,
    input  regIdxT rdAddr2,
    input  logic   wrEn,
    input  regIdxT wrAddr,
    input  wordT   wrData,
    output wordT   rdData1,
    output wordT   rdData2
);

    wordT regs [16];

    // R0 reads zero, same-cycle write is bypassed to the reader
    function automatic wordT readPort(regIdxT addr);
        if (addr == '0) begin
            return '0;
        end
        if (wrEn && wrAddr == addr) begin
            return wrData;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != '0) begin
            regs[wrAddr] <= wrData;
        end
    end

    always_comb begin
        rdData1 = readPort(rdAddr1);
        rdData2 = readPort(rdAddr2);
    end

endmodule

// ==== verilog/cpuPkg.sv ====
package cpuPkg;

    // Data and instruction word
    typedef logic [15:0] wordT;
    typedef logic [3:0]  regIdxT;

    // Unlisted codes decode as no-ops
    typedef enum logic [3:0] {
        OP_ADD = 4'd0,
        OP_SUB = 4'd1,
        OP_XOR = 4'd2,
        OP_SLL = 4'd3,
        OP_LW  = 4'd4,
        OP_SW  = 4'd5,
        OP_LDI = 4'd6,
        OP_B   = 4'd7,
        OP_HLT = 4'd15
    } opcodeE;

    // Branch conditions, flags ordered Z V N
    typedef enum logic [2:0] {
        COND_NE, COND_EQ, COND_GT, COND_LT, COND_GE, COND_LE, COND_OV, COND_UN
    } condE;

    typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_XOR, ALU_SLL} aluOpE;

    // Operand source in EX
    typedef enum logic [1:0] {FWD_NONE, FWD_MEM, FWD_WB} fwdSelE;

    // Second ALU operand select
    localparam logic [1:0] IMM_RT     = 2'd0;
    localparam logic [1:0] IMM_SHAMT  = 2'd1;
    localparam logic [1:0] IMM_OFFSET = 2'd2;
    localparam logic [1:0] IMM_BYTE   = 2'd3;

    localparam int MEM_DEPTH = 256;
    localparam int MEM_AW    = $clog2(MEM_DEPTH);

    // Opcode 8 is a no-op, used for bubbles in IF/ID
    localparam wordT NOP_INSTR = 16'h8000;

endpackage
